// File: Makefile
# Verilator build and run of the cache storage testbench

VERILATOR ?= verilator
TOP       ?= cache_store_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?=
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: design/associative_single_port_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module associative_single_port_array
    import cache_pkg::*;
#(
    parameter type entry_t = line_t,
    parameter int  num_set = `CACHE_NUM_SET,
    parameter int  num_way = `CACHE_NUM_WAY
)
(
    input  wire logic                                               clk_in,
    input  wire logic                                               reset_in,
    input  wire logic                                               access_en,
    input  wire logic [$bits(entry_t) / `BYTE_LEN_IN_BITS - 1 : 0]  write_en,
    input  wire set_addr_t                                          set_addr,
    input  wire way_vec_t                                           way_select,
    input  wire entry_t                                             write_entry,
    output entry_t [num_way - 1 : 0]                                read_set,
    output entry_t                                                  read_single_entry
);

    localparam int entry_bits = $bits(entry_t);
    localparam int mask_bits  = entry_bits / `BYTE_LEN_IN_BITS;

    way_vec_t                  way_select_q;
    logic [entry_bits - 1 : 0] single_entry;

    // ##############################
    // One RAM per way
    // ##############################

    for (genvar w = 0; w < num_way; w++)
    begin : g_way
        single_port_ram
        #(
            .entry_t     (entry_t),
            .num_set     (num_set)
        )
        way_ram_i
        (
            .clk_in      (clk_in),
            .reset_in    (reset_in),
            .access_en   (access_en & way_select[w]),
            .write_en    (write_en & {mask_bits{way_select[w]}}),
            .set_addr    (set_addr),
            .write_entry (write_entry),
            .read_entry  (read_set[w])
        );
    end

    // ##############################
    // Single entry selection
    // ##############################

    // Lines up with the RAM read data of the same access
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            way_select_q <= '0;
        end
        else
        begin
            way_select_q <= way_select;
        end
    end

    always_comb
    begin
        single_entry = '0;
        for (int w = 0; w < num_way; w++)
        begin
            single_entry = single_entry | (read_set[w] & {entry_bits{way_select_q[w]}});
        end
    end

    assign read_single_entry = single_entry;

endmodule

`default_nettype wire

// File: design/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ##############################
// Cache geometry
// ##############################

`define CACHE_NUM_SET     16
`define CACHE_NUM_WAY     4

// Valid bit plus tag fills exactly two bytes
`define CACHE_TAG_BITS    15

`define CACHE_LINE_BYTES  8
`define BYTE_LEN_IN_BITS  8

`endif

// File: design/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    typedef enum logic [1:0]
    {
        OP_LOOKUP   = 2'd0,
        OP_READ_WAY = 2'd1,
        OP_FILL     = 2'd2,
        OP_WRITE    = 2'd3
    } cache_op_t;

    typedef logic [$clog2(`CACHE_NUM_SET) - 1 : 0]                 set_addr_t;
    typedef logic [`CACHE_NUM_WAY - 1 : 0]                         way_vec_t;
    typedef logic [`CACHE_LINE_BYTES * `BYTE_LEN_IN_BITS - 1 : 0]  line_t;
    typedef logic [`CACHE_LINE_BYTES - 1 : 0]                      byte_mask_t;

    typedef struct packed
    {
        logic                            valid;
        logic [`CACHE_TAG_BITS - 1 : 0]  tag;
    } tag_entry_t;

    typedef struct packed
    {
        cache_op_t                       op;
        set_addr_t                       set;
        logic [`CACHE_TAG_BITS - 1 : 0]  tag;
        way_vec_t                        way;    // One-hot or multi-hot target ways
        byte_mask_t                      mask;   // Byte enables for a write
        line_t                           wdata;
    } cache_req_t;

    typedef struct packed
    {
        logic      hit;
        way_vec_t  hit_way;
        line_t     line;
    } cache_resp_t;

endpackage

`default_nettype wire

// File: design/cache_store_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_store_top
    import cache_pkg::*;
(
    input  wire logic        clk_in,
    input  wire logic        reset_in,
    input  wire logic        req_valid,
    input  wire cache_req_t  req,
    output logic             resp_valid,
    output cache_resp_t      resp
);

    localparam int tag_mask_bits = $bits(tag_entry_t) / `BYTE_LEN_IN_BITS;

    // ##############################
    // Request decode
    // ##############################

    way_vec_t                     way_sel;
    logic [tag_mask_bits - 1 : 0] tag_wen;
    byte_mask_t                   data_wen;
    tag_entry_t                   tag_wentry;

    tag_entry_t [`CACHE_NUM_WAY - 1 : 0] tag_set;
    line_t      [`CACHE_NUM_WAY - 1 : 0] line_set;
    tag_entry_t                          tag_single;
    line_t                               line_single;

    logic                           match_hit;
    way_vec_t                       match_way;
    line_t                          match_line;

    cache_op_t                      op_q;
    logic [`CACHE_TAG_BITS - 1 : 0] tag_q;
    way_vec_t                       way_q;
    logic                           resp_valid_q;

    assign way_sel = (req.op == OP_LOOKUP) ? '1 : req.way;    // A lookup searches every way

    always_comb
    begin
        tag_wen  = '0;
        data_wen = '0;
        if (req_valid && (req.op == OP_FILL))
        begin
            tag_wen  = '1;
            data_wen = '1;
        end
        else if (req_valid && (req.op == OP_WRITE))
        begin
            data_wen = req.mask;    // Tag stays as it is
        end
    end

    assign tag_wentry.valid = 1'b1;
    assign tag_wentry.tag   = req.tag;

    // ##############################
    // Storage and compare
    // ##############################

    associative_single_port_array
    #(
        .entry_t           (tag_entry_t),
        .num_set           (`CACHE_NUM_SET),
        .num_way           (`CACHE_NUM_WAY)
    )
    tag_array_i
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .access_en         (req_valid),
        .write_en          (tag_wen),
        .set_addr          (req.set),
        .way_select        (way_sel),
        .write_entry       (tag_wentry),
        .read_set          (tag_set),
        .read_single_entry (tag_single)
    );

    associative_single_port_array
    #(
        .entry_t           (line_t),
        .num_set           (`CACHE_NUM_SET),
        .num_way           (`CACHE_NUM_WAY)
    )
    data_array_i
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .access_en         (req_valid),
        .write_en          (data_wen),
        .set_addr          (req.set),
        .way_select        (way_sel),
        .write_entry       (req.wdata),
        .read_set          (line_set),
        .read_single_entry (line_single)
    );

    tag_match tag_match_i
    (
        .lookup_tag (tag_q),
        .tag_set    (tag_set),
        .line_set   (line_set),
        .hit        (match_hit),
        .hit_way    (match_way),
        .hit_line   (match_line)
    );

    // ##############################
    // Response stage
    // ##############################

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            resp_valid_q <= 1'b0;
            op_q         <= OP_LOOKUP;
        end
        else
        begin
            resp_valid_q <= req_valid && ((req.op == OP_LOOKUP) || (req.op == OP_READ_WAY));
            op_q         <= req.op;
        end
    end

    always_ff @(posedge clk_in)
    begin
        tag_q <= req.tag;
        way_q <= req.way;
    end

    always_comb
    begin
        if (op_q == OP_LOOKUP)
        begin
            resp.hit     = match_hit;
            resp.hit_way = match_way;
            resp.line    = match_line;
        end
        else
        begin
            resp.hit     = tag_single.valid;    // Named way holds a valid line
            resp.hit_way = way_q;
            resp.line    = line_single;
        end
    end

    assign resp_valid = resp_valid_q;

endmodule

`default_nettype wire

// File: design/single_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module single_port_ram
    import cache_pkg::*;
#(
    parameter type entry_t = line_t,
    parameter int  num_set = `CACHE_NUM_SET
)
(
    input  wire logic                                               clk_in,
    input  wire logic                                               reset_in,
    input  wire logic                                               access_en,
    input  wire logic [$bits(entry_t) / `BYTE_LEN_IN_BITS - 1 : 0]  write_en,
    input  wire set_addr_t                                          set_addr,
    input  wire entry_t                                             write_entry,
    output entry_t                                                  read_entry
);

    localparam int entry_bits = $bits(entry_t);
    localparam int num_bytes  = entry_bits / `BYTE_LEN_IN_BITS;

    logic [entry_bits - 1 : 0] mem [num_set];

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            for (int s = 0; s < num_set; s++)
            begin
                mem[s] <= '0;   // Every valid bit starts clear
            end
        end
        else if (access_en)
        begin
            for (int b = 0; b < num_bytes; b++)
            begin
                if (write_en[b])
                begin
                    mem[set_addr][b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS] <=
                        write_entry[b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
                end
            end
        end
    end

    // Old contents come out when a write hits the same set
    always_ff @(posedge clk_in)
    begin
        if (access_en)
        begin
            read_entry <= mem[set_addr];
        end
    end

endmodule

`default_nettype wire

// File: design/tag_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module tag_match
    import cache_pkg::*;
(
    input  wire logic [`CACHE_TAG_BITS - 1 : 0]     lookup_tag,
    input  wire tag_entry_t [`CACHE_NUM_WAY - 1 : 0] tag_set,
    input  wire line_t [`CACHE_NUM_WAY - 1 : 0]      line_set,
    output logic                                     hit,
    output way_vec_t                                 hit_way,
    output line_t                                    hit_line
);

    always_comb
    begin
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
        begin
            hit_way[w] = tag_set[w].valid && (tag_set[w].tag == lookup_tag);
        end
    end

    assign hit = |hit_way;

    // Walking down from the top leaves the lowest hitting way in place
    always_comb
    begin
        hit_line = '0;
        for (int w = `CACHE_NUM_WAY - 1; w >= 0; w--)
        begin
            if (hit_way[w])
            begin
                hit_line = line_set[w];
            end
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/cache_pkg.sv
design/single_port_ram.sv
design/associative_single_port_array.sv
design/tag_match.sv
design/cache_store_top.sv
test/cache_store_asserts.sv
test/cache_store_checker.sv
test/cache_store_tb.sv

// File: test/cache_store_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cache_store_asserts
    import cache_pkg::*;
(
    input wire logic        clk_in,
    input wire logic        reset_in,
    input wire logic        req_valid,
    input wire cache_req_t  req,
    input wire logic        resp_valid,
    input wire cache_resp_t resp
);

    logic read_req;
    logic lookup_req;
    int   fail_count = 0;

    assign read_req   = req_valid && ((req.op == OP_LOOKUP) || (req.op == OP_READ_WAY));
    assign lookup_req = req_valid && (req.op == OP_LOOKUP);

    a_resp_follows_read: assert property (
        @(posedge clk_in) disable iff (reset_in) read_req |=> resp_valid)
        else
        begin
            $error("resp_valid missing one cycle after a lookup or read_way");
            fail_count++;
        end

    a_no_stray_resp: assert property (
        @(posedge clk_in) disable iff (reset_in) resp_valid |-> $past(read_req))
        else
        begin
            $error("resp_valid raised without a lookup or read_way one cycle before");
            fail_count++;
        end

    // Tags are never duplicated within a set, so at most one way may hit
    a_lookup_one_way: assert property (
        @(posedge clk_in) disable iff (reset_in)
        (resp_valid && $past(lookup_req)) |-> $onehot0(resp.hit_way))
        else
        begin
            $error("lookup response has more than one hitting way");
            fail_count++;
        end

    a_hit_has_way: assert property (
        @(posedge clk_in) disable iff (reset_in) (resp_valid && resp.hit) |-> (resp.hit_way != '0))
        else
        begin
            $error("hit reported with an empty way vector");
            fail_count++;
        end

    a_quiet_in_reset: assert property (
        @(posedge clk_in) reset_in |-> !resp_valid)
        else
        begin
            $error("resp_valid high during reset");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: test/cache_store_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_store_checker
    import cache_pkg::*;
#(
    parameter int name_chars = 20
)
(
    input  wire logic                          clk_in,
    input  wire logic                          reset_in,
    input  wire logic                          req_valid,
    input  wire cache_req_t                    req,
    input  wire logic                          resp_valid,
    input  wire cache_resp_t                   resp,
    input  wire logic [8 * name_chars - 1 : 0] test_name,
    output int                                 error_count
);

    tag_entry_t                    tag_model  [`CACHE_NUM_SET][`CACHE_NUM_WAY];
    line_t                         line_model [`CACHE_NUM_SET][`CACHE_NUM_WAY];
    logic                          pending;
    cache_resp_t                   expected;
    logic [8 * name_chars - 1 : 0] pending_name;

    function automatic cache_resp_t predict(input cache_req_t r);
        cache_resp_t p;
        p = '0;
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
        begin
            if (r.op == OP_LOOKUP)
            begin
                if (tag_model[r.set][w].valid && (tag_model[r.set][w].tag == r.tag))
                begin
                    if (!p.hit)
                    begin
                        p.line = line_model[r.set][w];    // Lowest hitting way supplies the line
                    end
                    p.hit        = 1'b1;
                    p.hit_way[w] = 1'b1;
                end
            end
            else if (r.way[w])
            begin
                p.hit_way[w] = 1'b1;
                p.hit        = p.hit | tag_model[r.set][w].valid;
                p.line       = p.line | line_model[r.set][w];
            end
        end
        return p;
    endfunction

    task automatic update_model(input cache_req_t r);
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
        begin
            if (r.way[w] && (r.op == OP_FILL))
            begin
                tag_model[r.set][w]  = '{valid: 1'b1, tag: r.tag};
                line_model[r.set][w] = r.wdata;
            end
            else if (r.way[w] && (r.op == OP_WRITE))
            begin
                for (int b = 0; b < `CACHE_LINE_BYTES; b++)
                begin
                    if (r.mask[b])
                    begin
                        line_model[r.set][w][b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS] =
                            r.wdata[b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
                    end
                end
            end
        end
    endtask

    task automatic check_response();
        if (resp_valid && !pending)
        begin
            error_count++;
            $display("Response arrived at %0t ns without a lookup or read_way before it", $time);
        end
        else if (!resp_valid && pending)
        begin
            error_count++;
            $display("Request %s got no response one cycle later", pending_name);
        end
        else if (resp_valid && (resp !== expected))
        begin
            error_count++;
            $display("Error %s: expected hit=%0b way=%b line=%h, actual hit=%0b way=%b line=%h",
                     pending_name, expected.hit, expected.hit_way, expected.line,
                     resp.hit, resp.hit_way, resp.line);
        end
    endtask

    // ##############################
    // Sampling at the falling edge
    // ##############################

    always @(negedge clk_in)
    begin
        if (reset_in)
        begin
            for (int s = 0; s < `CACHE_NUM_SET; s++)
            begin
                for (int w = 0; w < `CACHE_NUM_WAY; w++)
                begin
                    tag_model[s][w]  = '0;
                    line_model[s][w] = '0;
                end
            end
            pending = 1'b0;
        end
        else
        begin
            check_response();
            pending = req_valid && ((req.op == OP_LOOKUP) || (req.op == OP_READ_WAY));
            if (req_valid)
            begin
                expected     = predict(req);    // Reads see the contents before this request
                pending_name = test_name;
                update_model(req);
            end
        end
    end

endmodule

`default_nettype wire

// File: test/cache_store_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_store_tb
    import cache_pkg::*;
();

    localparam int clk_period   = 8;
    localparam int reset_cycles = 4;
    localparam int name_chars   = 20;
    localparam int margin       = 20;
    localparam logic [31:0] rand_seed = 32'hd198;

    typedef struct packed
    {
        logic [8 * name_chars - 1 : 0]   name;
        cache_op_t                       op;
        set_addr_t                       set;
        logic [`CACHE_TAG_BITS - 1 : 0]  tag;
        way_vec_t                        way;
        byte_mask_t                      mask;
    } stim_row_t;

    logic                          clk_in;
    logic                          reset_in;
    logic                          req_valid;
    cache_req_t                    req;
    logic                          resp_valid;
    cache_resp_t                   resp;
    logic [8 * name_chars - 1 : 0] test_name;
    int                            error_count;
    int                            cycle_count;
    stim_row_t                     stim_table [$];

    cache_store_top dut_i
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    cache_store_checker #(.name_chars (name_chars)) checker_i
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .req_valid   (req_valid),
        .req         (req),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .test_name   (test_name),
        .error_count (error_count)
    );

    bind cache_store_top cache_store_asserts asserts_i (.*);

    initial
    begin
        clk_in = 1'b0;
        forever
        begin
            #(clk_period / 2) clk_in = ~clk_in;
        end
    end

    always @(posedge clk_in)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > reset_cycles + stim_table.size() + margin)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_count - 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [8 * name_chars - 1 : 0] pack_name(input string s);
        logic [8 * name_chars - 1 : 0] packed_name;
        packed_name = '0;
        for (int i = 0; (i < s.len()) && (i < name_chars); i++)
        begin
            packed_name = {packed_name[8 * name_chars - 9 : 0], s[i]};
        end
        return packed_name;
    endfunction

    task automatic add_row(input string name, input cache_op_t op, input set_addr_t set,
                           input logic [`CACHE_TAG_BITS - 1 : 0] tag, input way_vec_t way,
                           input byte_mask_t mask);
        stim_row_t row;
        row.name = pack_name(name);
        row.op   = op;
        row.set  = set;
        row.tag  = tag;
        row.way  = way;
        row.mask = mask;
        stim_table.push_back(row);
    endtask

    // ##############################
    // Stimulus table
    // ##############################

    task automatic build_table();
        add_row("reset_miss_s0", OP_LOOKUP, 4'd0, 15'h0000, 4'b0000, 8'h00);
        add_row("reset_miss_s5", OP_LOOKUP, 4'd5, 15'h1234, 4'b0000, 8'h00);
        add_row("reset_miss_s15", OP_LOOKUP, 4'd15, 15'h7fff, 4'b0000, 8'h00);
        add_row("fill_s3_w1", OP_FILL, 4'd3, 15'h0abc, 4'b0010, 8'h00);
        add_row("hit_s3_w1", OP_LOOKUP, 4'd3, 15'h0abc, 4'b0000, 8'h00);
        add_row("miss_s3_tag", OP_LOOKUP, 4'd3, 15'h0abd, 4'b0000, 8'h00);
        add_row("write_s3_w1", OP_WRITE, 4'd3, 15'h0000, 4'b0010, 8'b0101_0011);
        add_row("lookup_after_write", OP_LOOKUP, 4'd3, 15'h0abc, 4'b0000, 8'h00);
        add_row("read_way_s3_w1", OP_READ_WAY, 4'd3, 15'h5a5a, 4'b0010, 8'h00);
        add_row("read_way_s3_w2_empty", OP_READ_WAY, 4'd3, 15'h0abc, 4'b0100, 8'h00);
        add_row("fill_s7_w0", OP_FILL, 4'd7, 15'h0111, 4'b0001, 8'h00);
        add_row("fill_s7_w2", OP_FILL, 4'd7, 15'h0222, 4'b0100, 8'h00);
        add_row("fill_s7_w3", OP_FILL, 4'd7, 15'h0333, 4'b1000, 8'h00);
        add_row("fill_s8_w0", OP_FILL, 4'd8, 15'h0444, 4'b0001, 8'h00);
        add_row("fill_s9_w0", OP_FILL, 4'd9, 15'h0555, 4'b0001, 8'h00);
        add_row("hit_s7_w0", OP_LOOKUP, 4'd7, 15'h0111, 4'b0000, 8'h00);
        add_row("hit_s7_w2", OP_LOOKUP, 4'd7, 15'h0222, 4'b0000, 8'h00);
        add_row("hit_s7_w3", OP_LOOKUP, 4'd7, 15'h0333, 4'b0000, 8'h00);
        add_row("hit_s8_w0", OP_LOOKUP, 4'd8, 15'h0444, 4'b0000, 8'h00);
        add_row("hit_s9_w0", OP_LOOKUP, 4'd9, 15'h0555, 4'b0000, 8'h00);
        add_row("miss_s8_other_tag", OP_LOOKUP, 4'd8, 15'h0111, 4'b0000, 8'h00);
        add_row("read_way_s7_w3", OP_READ_WAY, 4'd7, 15'h0000, 4'b1000, 8'h00);
        add_row("refill_s7_w0", OP_FILL, 4'd7, 15'h0666, 4'b0001, 8'h00);
        add_row("hit_after_refill", OP_LOOKUP, 4'd7, 15'h0666, 4'b0000, 8'h00);
        add_row("miss_old_tag", OP_LOOKUP, 4'd7, 15'h0111, 4'b0000, 8'h00);
        add_row("write_s7_w2", OP_WRITE, 4'd7, 15'h0000, 4'b0100, 8'b1000_0001);
        add_row("read_after_write", OP_READ_WAY, 4'd7, 15'h0000, 4'b0100, 8'h00);
        add_row("fill_s12_w1", OP_FILL, 4'd12, 15'h0777, 4'b0010, 8'h00);
        add_row("read_after_fill", OP_READ_WAY, 4'd12, 15'h0000, 4'b0010, 8'h00);
        add_row("hit_s3_still", OP_LOOKUP, 4'd3, 15'h0abc, 4'b0000, 8'h00);
        add_row("hit_s7_w2_after_wr", OP_LOOKUP, 4'd7, 15'h0222, 4'b0000, 8'h00);
    endtask

    task automatic apply_row(input stim_row_t row);
        @(posedge clk_in);
        #1;
        req_valid = 1'b1;
        req.op    = row.op;
        req.set   = row.set;
        req.tag   = row.tag;
        req.way   = row.way;
        req.mask  = row.mask;
        req.wdata = {$urandom, $urandom};    // Fresh line data on every request
        test_name = row.name;
    endtask

    initial
    begin
        void'($urandom(rand_seed));
        reset_in  = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        test_name = '0;
        build_table();
        repeat (reset_cycles) @(posedge clk_in);
        #1 reset_in = 1'b0;
        foreach (stim_table[i])
        begin
            apply_row(stim_table[i]);
        end
        @(posedge clk_in);
        #1;
        req_valid = 1'b0;
        req       = '0;
        repeat (2) @(posedge clk_in);    // Last response is sampled in between
        $display("Done: %0d tests, %0d checker errors, %0d assertion failures",
                 stim_table.size(), error_count, dut_i.asserts_i.fail_count);
        if ((error_count == 0) && (dut_i.asserts_i.fail_count == 0))
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
